// ==== build.f ====
verilog/mem_map_pkg.sv
verilog/mem_router.sv
verilog/shared_ram.sv
verilog/debug_apb_bridge.sv
verilog/mem_subsystem_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_mem_subsystem -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^RESULT: PASS$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== sim/tb_mem_subsystem.sv ====
// Testbench of the memory subsystem that drives both core ports and models the debug module
// Runs from build.f and prints one line per test and a closing result line
module tb_mem_subsystem;
  import mem_map_pkg::*;

  localparam addr_t TOHOST_ADDR = 32'h8000_1000;
  localparam int    TIMEOUT     = 20000;

  logic      clk;
  logic      reset_n;
  logic      debug_mode;
  imem_req_t imem_req;
  dmem_req_t dmem_req;
  apb_rsp_t  apb_rsp;
  imem_rsp_t imem_rsp;
  dmem_rsp_t dmem_rsp;
  apb_req_t  apb_req;
  data_t     tohost;

  integer seed = 46509;
  int     cyc = 0;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     err_base = 0;
  // Expected data and state of the outstanding reads
  data_t  d_exp, i_exp;
  logic   d_pending = 0, i_pending = 0, d_done = 0, i_done = 0;
  int     d_issue, i_issue, d_lat, i_lat;
  data_t  shadow [RAM_WORDS];
  // Debug module model
  data_t  dbg_regs [16];
  logic [1:0] wait_left;
  logic   inject_err;
  logic   psel_prev = 0;
  int     psel_cycles = 0;
  int     apb_xfers = 0;
  apb_addr_t last_paddr;
  logic   last_pwrite;
  data_t  last_pwdata;

  tb_clock_gen u_tb_clock_gen (.clk(clk), .reset_n(reset_n));

  mem_subsystem_top #(
    .TOHOST_ADDR(TOHOST_ADDR),
    .RAM_DEPTH  (RAM_WORDS)
  ) u_mem_subsystem_top (
    .clk(clk), .reset_n(reset_n), .i_debug_mode(debug_mode),
    .i_imem_req(imem_req), .i_dmem_req(dmem_req), .i_apb_rsp(apb_rsp),
    .o_imem_rsp(imem_rsp), .o_dmem_rsp(dmem_rsp), .o_apb_req(apb_req),
    .o_tohost(tohost)
  );

  // ====================
  // Reference model
  // ====================
  function automatic logic in_ram_window(addr_t a);
    return (a[31:14] == 18'h00004) || (a[31:14] == 18'h3FFFF);
  endfunction

  // Debug area only in debug mode, RAM through either window, zero elsewhere
  function automatic data_t expected_read(addr_t a, logic dbg);
    if (dbg && (a >= 32'h200) && (a <= 32'hFFF))
      return dbg_regs[a[5:2]];
    if (in_ram_window(a))
      return shadow[a[13:2]];
    return '0;
  endfunction

  task automatic report_mismatch(string name, data_t exp, data_t got);
    errors++;
    $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic report_error(string msg);
    errors++;
    $display("Error at time %0t: %s", $time, msg);
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (errors == err_base)
      $display("Test %0d %s: passed", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - err_base);
    end
    err_base = errors;
  endtask

  // ====================
  // Core port drivers
  // ====================
  task automatic load(input addr_t a, output int lat);
    @(posedge clk);
    d_exp = expected_read(a, debug_mode);
    d_issue = cyc + 1;
    d_done = 0;
    d_pending = 1;
    dmem_req.rready <= 1'b1;
    dmem_req.addr   <= a;
    while (!d_done) @(posedge clk);
    dmem_req.rready <= 1'b0;
    lat = d_lat;
  endtask

  task automatic fetch(input addr_t a, output int lat);
    @(posedge clk);
    i_exp = expected_read(a, debug_mode);
    i_issue = cyc + 1;
    i_done = 0;
    i_pending = 1;
    imem_req.rready <= 1'b1;
    imem_req.addr   <= a;
    while (!i_done) @(posedge clk);
    imem_req.rready <= 1'b0;
    lat = i_lat;
  endtask

  // Returns the number of cycles wready came after the first request cycle
  task automatic store(input addr_t a, input data_t v, output int lat);
    int n;
    n = 0;
    @(posedge clk);
    dmem_req.wvalid <= 1'b1;
    dmem_req.addr   <= a;
    dmem_req.wdata  <= v;
    @(negedge clk);
    while (!dmem_rsp.wready)
    begin
      n++;
      @(negedge clk);
    end
    @(posedge clk);
    dmem_req.wvalid <= 1'b0;
    if (in_ram_window(a) && !(debug_mode && a <= 32'hFFF))
      shadow[a[13:2]] = v;
    lat = n;
  endtask

  task automatic check_apb(addr_t a, logic wr, data_t v, int xfers_before);
    // The APB model records the transfer at the edge where pready is seen
    @(negedge clk);
    if (apb_xfers != xfers_before + 1)
      report_error("debug access did not make exactly one APB transfer");
    if (last_paddr !== a[12:0])
      report_mismatch("paddr", data_t'(a[12:0]), data_t'(last_paddr));
    if (last_pwrite !== wr)
      report_mismatch("pwrite", data_t'(wr), data_t'(last_pwrite));
    if (wr && last_pwdata !== v)
      report_mismatch("pwdata", v, last_pwdata);
  endtask

  // ====================
  // Compare process
  // ====================
  always @(negedge clk)
  begin
    if (reset_n && dmem_rsp.rvalid)
    begin
      if (!d_pending)
        report_error("data rvalid without a pending load");
      else
      begin
        if (dmem_rsp.rdata !== d_exp)
          report_mismatch("o_dmem_rsp.rdata", d_exp, dmem_rsp.rdata);
        d_lat = cyc - d_issue;
        d_pending = 0;
        d_done = 1;
      end
    end
    if (reset_n && imem_rsp.rvalid)
    begin
      if (!i_pending)
        report_error("fetch rvalid without a pending fetch");
      else
      begin
        if (imem_rsp.rdata !== i_exp)
          report_mismatch("o_imem_rsp.rdata", i_exp, imem_rsp.rdata);
        i_lat = cyc - i_issue;
        i_pending = 0;
        i_done = 1;
      end
    end
  end

  // ====================
  // Debug module APB slave
  // ====================
  always @(posedge clk)
  begin
    if (apb_req.penable && !psel_prev)
      report_error("penable rose without a setup cycle");
    psel_prev <= apb_req.psel;
    if (apb_req.psel)
      psel_cycles++;
    if (apb_rsp.pready)
    begin
      apb_rsp.pready  <= 1'b0;
      apb_rsp.pslverr <= 1'b0;
      if (apb_req.penable)
      begin
        apb_xfers++;
        last_paddr  = apb_req.paddr;
        last_pwrite = apb_req.pwrite;
        last_pwdata = apb_req.pwdata;
      end
    end
    else if (apb_req.psel && !apb_req.penable)
      wait_left <= $random(seed) & 3;
    else if (apb_req.psel && apb_req.penable)
    begin
      if (wait_left == 0)
      begin
        apb_rsp.pready  <= 1'b1;
        apb_rsp.pslverr <= inject_err;
        apb_rsp.prdata  <= dbg_regs[apb_req.paddr[5:2]];
        if (apb_req.pwrite)
          dbg_regs[apb_req.paddr[5:2]] <= apb_req.pwdata;
      end
      else
        wait_left <= wait_left - 1;
    end
  end

  // Run limit well above the length of all tests
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ====================
  // Test sequence
  // ====================
  initial
  begin
    addr_t a_list [8];
    int    lat, lat_i;
    int    xf, ps;
    imem_req   = '0;
    dmem_req   = '0;
    apb_rsp    = '0;
    debug_mode = 1'b0;
    inject_err = 1'b0;
    wait_left  = '0;
    for (int i = 0; i < 16; i++)
      dbg_regs[i] = 32'hD0B6_0000 ^ (i * 32'h0101_0107);

    // Reset state
    wait (reset_n);
    @(negedge clk);
    if (imem_rsp.rvalid || dmem_rsp.rvalid || dmem_rsp.wready)
      report_error("response strobe active after reset");
    if (apb_req.psel || apb_req.penable)
      report_error("APB select or enable active after reset");
    if (tohost !== '0)
      report_mismatch("o_tohost", '0, tohost);
    finish_test("reset state");

    // RAM writes, then loads and fetches through both windows
    for (int i = 0; i < 8; i++)
    begin
      a_list[i] = RAM_BASE + {18'd0, 12'(i * 37 + ($random(seed) & 31)), 2'b00};
      store(a_list[i], $random(seed), lat);
      if (lat != 0)
        report_error("RAM write not acknowledged in the request cycle");
    end
    for (int i = 0; i < 8; i++)
    begin
      load(a_list[i], lat);
      fetch(a_list[i] | 32'hFFFF_C000, lat);
      load(a_list[i] | 32'hFFFF_C000, lat);
    end
    finish_test("RAM write and read");

    // Fetch and load together
    for (int i = 0; i < 4; i++)
    begin
      fork
        load(a_list[i], lat);
        fetch(a_list[7 - i], lat_i);
      join
      if (lat != 2)
        report_mismatch("data read latency", 2, data_t'(lat));
    end
    finish_test("concurrent reads");

    // Debug area over APB
    @(posedge clk);
    debug_mode <= 1'b1;
    xf = apb_xfers;
    store(32'h0000_0404, 32'h1234_ABCD, lat);
    check_apb(32'h0000_0404, 1'b1, 32'h1234_ABCD, xf);
    xf = apb_xfers;
    load(32'h0000_0404, lat);
    check_apb(32'h0000_0404, 1'b0, '0, xf);
    xf = apb_xfers;
    fetch(32'h0000_0248, lat);
    check_apb(32'h0000_0248, 1'b0, '0, xf);
    inject_err = 1'b1;
    xf = apb_xfers;
    load(32'h0000_0310, lat);
    check_apb(32'h0000_0310, 1'b0, '0, xf);
    inject_err = 1'b0;
    @(posedge clk);
    debug_mode <= 1'b0;
    @(posedge clk);
    ps = psel_cycles;
    load(32'h0000_0404, lat);
    if (lat != 0)
      report_error("debug-area load out of debug mode did not answer at once");
    fetch(32'h0000_0248, lat);
    if (lat != 0)
      report_error("debug-area fetch out of debug mode did not answer at once");
    @(negedge clk);
    if (psel_cycles != ps)
      report_error("psel rose out of debug mode");
    finish_test("debug-mode access");

    // tohost and unmapped addresses
    store(TOHOST_ADDR, 32'hCAFE_0001, lat);
    @(negedge clk);
    if (tohost !== 32'hCAFE_0001)
      report_mismatch("o_tohost", 32'hCAFE_0001, tohost);
    load(32'h0005_0000, lat);
    if (lat != 0)
      report_error("unmapped load did not answer in the same cycle");
    fetch(32'h7000_0000, lat);
    if (lat != 0)
      report_error("unmapped fetch did not answer in the same cycle");
    store(RAM_BASE, 32'h5A5A_0F0F, lat);
    store(32'h0002_4000, 32'hDEAD_BEEF, lat);
    if (lat != 0)
      report_error("unmapped write not acknowledged in the same cycle");
    load(RAM_BASE, lat);
    finish_test("tohost and unmapped");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sim/tb_clock_gen.sv ====
// Clock and reset source for the testbench
// clk period 100, reset_n held low for the first 8 rising edges
module tb_clock_gen (
  output logic clk,
  output logic reset_n
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    reset_n = 1'b0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

// ==== verilog/mem_subsystem_top.sv ====
// Memory-side fabric of the hart, wires router, shared RAM and debug bridge
// Core fetch and data ports in, APB to the debug module and tohost out
module mem_subsystem_top #(
  parameter mem_map_pkg::addr_t TOHOST_ADDR = 32'h8000_1000,
  parameter int                 RAM_DEPTH   = mem_map_pkg::RAM_WORDS
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   i_debug_mode,
  input  mem_map_pkg::imem_req_t i_imem_req,
  input  mem_map_pkg::dmem_req_t i_dmem_req,
  input  mem_map_pkg::apb_rsp_t  i_apb_rsp,
  output mem_map_pkg::imem_rsp_t o_imem_rsp,
  output mem_map_pkg::dmem_rsp_t o_dmem_rsp,
  output mem_map_pkg::apb_req_t  o_apb_req,
  output mem_map_pkg::data_t     o_tohost
);
  import mem_map_pkg::*;

  // Router to RAM
  logic      ram_imem_rd;
  word_idx_t ram_imem_idx;
  logic      ram_dmem_rd;
  logic      ram_dmem_wr;
  word_idx_t ram_dmem_idx;
  data_t     ram_wdata;
  logic      ram_imem_valid;
  data_t     ram_imem_rdata;
  logic      ram_dmem_valid;
  data_t     ram_dmem_rdata;
  // Router to bridge
  logic      dbg_imem_req;
  apb_addr_t dbg_imem_addr;
  logic      dbg_dmem_req;
  logic      dbg_dmem_write;
  apb_addr_t dbg_dmem_addr;
  data_t     dbg_wdata;
  logic      dbg_imem_done;
  logic      dbg_dmem_done;
  data_t     dbg_rdata;

  mem_router #(
    .TOHOST_ADDR(TOHOST_ADDR),
    .RAM_DEPTH  (RAM_DEPTH)
  ) u_mem_router (
    .clk(clk), .reset_n(reset_n), .i_debug_mode(i_debug_mode),
    .i_imem_req(i_imem_req), .i_dmem_req(i_dmem_req),
    .o_imem_rsp(o_imem_rsp), .o_dmem_rsp(o_dmem_rsp), .o_tohost(o_tohost),
    .o_ram_imem_rd(ram_imem_rd), .o_ram_imem_idx(ram_imem_idx),
    .o_ram_dmem_rd(ram_dmem_rd), .o_ram_dmem_wr(ram_dmem_wr),
    .o_ram_dmem_idx(ram_dmem_idx), .o_ram_wdata(ram_wdata),
    .i_ram_imem_valid(ram_imem_valid), .i_ram_imem_rdata(ram_imem_rdata),
    .i_ram_dmem_valid(ram_dmem_valid), .i_ram_dmem_rdata(ram_dmem_rdata),
    .o_dbg_imem_req(dbg_imem_req), .o_dbg_imem_addr(dbg_imem_addr),
    .o_dbg_dmem_req(dbg_dmem_req), .o_dbg_dmem_write(dbg_dmem_write),
    .o_dbg_dmem_addr(dbg_dmem_addr), .o_dbg_wdata(dbg_wdata),
    .i_dbg_imem_done(dbg_imem_done), .i_dbg_dmem_done(dbg_dmem_done),
    .i_dbg_rdata(dbg_rdata)
  );

  shared_ram #(
    .RAM_DEPTH(RAM_DEPTH)
  ) u_shared_ram (
    .clk(clk), .reset_n(reset_n),
    .i_imem_rd(ram_imem_rd), .i_imem_idx(ram_imem_idx),
    .i_dmem_rd(ram_dmem_rd), .i_dmem_wr(ram_dmem_wr),
    .i_dmem_idx(ram_dmem_idx), .i_wdata(ram_wdata),
    .o_imem_valid(ram_imem_valid), .o_imem_rdata(ram_imem_rdata),
    .o_dmem_valid(ram_dmem_valid), .o_dmem_rdata(ram_dmem_rdata)
  );

  debug_apb_bridge u_debug_apb_bridge (
    .clk(clk), .reset_n(reset_n), .i_debug_mode(i_debug_mode),
    .i_imem_req(dbg_imem_req), .i_imem_addr(dbg_imem_addr),
    .i_dmem_req(dbg_dmem_req), .i_dmem_write(dbg_dmem_write),
    .i_dmem_addr(dbg_dmem_addr), .i_wdata(dbg_wdata),
    .i_apb_rsp(i_apb_rsp),
    .o_imem_done(dbg_imem_done), .o_dmem_done(dbg_dmem_done),
    .o_rdata(dbg_rdata), .o_apb_req(o_apb_req)
  );

endmodule

// ==== verilog/debug_apb_bridge.sv ====
// APB master towards the external debug module
// Serves debug-area fetches and loads/stores, data port first
module debug_apb_bridge (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   i_debug_mode,
  input  logic                   i_imem_req,
  input  mem_map_pkg::apb_addr_t i_imem_addr,
  input  logic                   i_dmem_req,
  input  logic                   i_dmem_write,
  input  mem_map_pkg::apb_addr_t i_dmem_addr,
  input  mem_map_pkg::data_t     i_wdata,
  input  mem_map_pkg::apb_rsp_t  i_apb_rsp,
  output logic                   o_imem_done,
  output logic                   o_dmem_done,
  output mem_map_pkg::data_t     o_rdata,
  output mem_map_pkg::apb_req_t  o_apb_req
);
  import mem_map_pkg::*;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  apb_state_e state_q;
  apb_state_e state_d;
  // Set when the data port owns the transfer
  logic       owner_dmem_q;
  apb_addr_t  paddr_q;
  logic       pwrite_q;
  data_t      pwdata_q;
  logic       start;
  logic       xfer_end;

  assign start    = (state_q == APB_IDLE) && (i_imem_req || i_dmem_req);
  assign xfer_end = (state_q == APB_ACCESS) && i_apb_rsp.pready;

  // ====================
  // Transfer FSM
  // ====================
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      APB_IDLE:
        if (start)
          state_d = APB_SETUP;
      APB_SETUP:
        state_d = APB_ACCESS;
      // pslverr does not stall, the transfer ends on pready
      APB_ACCESS:
        if (i_apb_rsp.pready)
          state_d = APB_IDLE;
      default:
        state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q      <= APB_IDLE;
      owner_dmem_q <= 1'b0;
    end
    else if (!i_debug_mode)
      // Leaving debug mode drops any transfer
      state_q <= APB_IDLE;
    else
    begin
      state_q <= state_d;
      if (start)
        owner_dmem_q <= i_dmem_req;
    end
  end

  // Request fields held for the whole transfer
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      paddr_q  <= i_dmem_req ? i_dmem_addr : i_imem_addr;
      pwrite_q <= i_dmem_req && i_dmem_write;
      pwdata_q <= i_wdata;
    end
  end

  always_comb
  begin
    o_apb_req.psel    = (state_q != APB_IDLE);
    o_apb_req.penable = (state_q == APB_ACCESS);
    o_apb_req.pwrite  = pwrite_q;
    o_apb_req.paddr   = paddr_q;
    o_apb_req.pwdata  = pwdata_q;
  end

  // Done goes back to the owner in the pready cycle
  assign o_dmem_done = xfer_end && owner_dmem_q;
  assign o_imem_done = xfer_end && !owner_dmem_q;
  assign o_rdata     = i_apb_rsp.prdata;

  // penable only after a setup cycle with psel
  a_setup_first: assert property (@(posedge clk) disable iff (!reset_n)
    o_apb_req.penable |-> o_apb_req.psel && $past(o_apb_req.psel));

  // Fields stay put until the access ends
  a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
    o_apb_req.psel && !xfer_end && i_debug_mode |=>
      o_apb_req.psel && $stable(o_apb_req.paddr) &&
      $stable(o_apb_req.pwrite) && $stable(o_apb_req.pwdata));

  // Debug module flags errors only together with pready
  a_slverr_ready: assert property (@(posedge clk) disable iff (!reset_n)
    o_apb_req.penable && i_apb_rsp.pslverr |-> i_apb_rsp.pready);

endmodule

// ==== verilog/shared_ram.sv ====
// Single-port word RAM shared by the fetch and data ports
// One access per cycle with read data two cycles after the grant
module shared_ram #(
  parameter int RAM_DEPTH = mem_map_pkg::RAM_WORDS
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   i_imem_rd,
  input  mem_map_pkg::word_idx_t i_imem_idx,
  input  logic                   i_dmem_rd,
  input  logic                   i_dmem_wr,
  input  mem_map_pkg::word_idx_t i_dmem_idx,
  input  mem_map_pkg::data_t     i_wdata,
  output logic                   o_imem_valid,
  output mem_map_pkg::data_t     o_imem_rdata,
  output logic                   o_dmem_valid,
  output mem_map_pkg::data_t     o_dmem_rdata
);
  import mem_map_pkg::*;

  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_DMEM_WR,
    GRANT_DMEM_RD,
    GRANT_IMEM_RD
  } ram_grant_e;

  data_t      mem [RAM_DEPTH];
  data_t      rd_data_q;
  word_idx_t  ram_idx;
  ram_grant_e grant;
  ram_grant_e grant_q;
  // Per-port flag for a read issued and not yet returned
  logic       imem_busy_q;
  logic       dmem_busy_q;

  // ====================
  // Fixed priority grant
  // ====================
  always_comb
  begin
    grant   = GRANT_NONE;
    ram_idx = i_dmem_idx;
    if (i_dmem_wr)
      grant = GRANT_DMEM_WR;
    else if (i_dmem_rd && !dmem_busy_q)
      grant = GRANT_DMEM_RD;
    else if (i_imem_rd && !imem_busy_q)
    begin
      grant   = GRANT_IMEM_RD;
      ram_idx = i_imem_idx;
    end
  end

  // Read data register loads in the grant cycle
  always_ff @(posedge clk)
  begin
    if (grant == GRANT_DMEM_WR)
      mem[ram_idx] <= i_wdata;
    else if (grant != GRANT_NONE)
      rd_data_q <= mem[ram_idx];
  end

  // ====================
  // Grant record and valids
  // ====================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      grant_q      <= GRANT_NONE;
      imem_busy_q  <= 1'b0;
      dmem_busy_q  <= 1'b0;
      o_imem_valid <= 1'b0;
      o_dmem_valid <= 1'b0;
    end
    else
    begin
      grant_q      <= grant;
      o_imem_valid <= (grant_q == GRANT_IMEM_RD);
      o_dmem_valid <= (grant_q == GRANT_DMEM_RD);
      // Busy until the valid pulse has been seen by the core
      if (grant == GRANT_IMEM_RD)
        imem_busy_q <= 1'b1;
      else if (o_imem_valid)
        imem_busy_q <= 1'b0;
      if (grant == GRANT_DMEM_RD)
        dmem_busy_q <= 1'b1;
      else if (o_dmem_valid)
        dmem_busy_q <= 1'b0;
    end
  end

  // Output registers follow the port that owned the read
  always_ff @(posedge clk)
  begin
    if (grant_q == GRANT_IMEM_RD)
      o_imem_rdata <= rd_data_q;
    if (grant_q == GRANT_DMEM_RD)
      o_dmem_rdata <= rd_data_q;
  end

  // A port gets no new read grant while its read is in flight
  a_imem_one_read: assert property (@(posedge clk) disable iff (!reset_n)
    grant == GRANT_IMEM_RD |->
      ($past(grant) != GRANT_IMEM_RD) && ($past(grant, 2) != GRANT_IMEM_RD));

  a_dmem_one_read: assert property (@(posedge clk) disable iff (!reset_n)
    grant == GRANT_DMEM_RD |->
      ($past(grant) != GRANT_DMEM_RD) && ($past(grant, 2) != GRANT_DMEM_RD));

endmodule

// ==== verilog/mem_router.sv ====
// Address decode and response mux for the fetch and data ports of the core
// Steers each request to the shared RAM or the debug APB bridge and keeps tohost
module mem_router #(
  parameter mem_map_pkg::addr_t TOHOST_ADDR = 32'h8000_1000,
  parameter int                 RAM_DEPTH   = mem_map_pkg::RAM_WORDS
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   i_debug_mode,
  input  mem_map_pkg::imem_req_t i_imem_req,
  input  mem_map_pkg::dmem_req_t i_dmem_req,
  output mem_map_pkg::imem_rsp_t o_imem_rsp,
  output mem_map_pkg::dmem_rsp_t o_dmem_rsp,
  output mem_map_pkg::data_t     o_tohost,
  // Shared RAM side
  output logic                   o_ram_imem_rd,
  output mem_map_pkg::word_idx_t o_ram_imem_idx,
  output logic                   o_ram_dmem_rd,
  output logic                   o_ram_dmem_wr,
  output mem_map_pkg::word_idx_t o_ram_dmem_idx,
  output mem_map_pkg::data_t     o_ram_wdata,
  input  logic                   i_ram_imem_valid,
  input  mem_map_pkg::data_t     i_ram_imem_rdata,
  input  logic                   i_ram_dmem_valid,
  input  mem_map_pkg::data_t     i_ram_dmem_rdata,
  // Debug APB bridge side
  output logic                   o_dbg_imem_req,
  output mem_map_pkg::apb_addr_t o_dbg_imem_addr,
  output logic                   o_dbg_dmem_req,
  output logic                   o_dbg_dmem_write,
  output mem_map_pkg::apb_addr_t o_dbg_dmem_addr,
  output mem_map_pkg::data_t     o_dbg_wdata,
  input  logic                   i_dbg_imem_done,
  input  logic                   i_dbg_dmem_done,
  input  mem_map_pkg::data_t     i_dbg_rdata
);
  import mem_map_pkg::*;

  // RAM window size in bytes within the 14 offset bits
  localparam addr_t RAM_BYTES = addr_t'(RAM_DEPTH * 4);

  region_e imem_region;
  region_e dmem_region;

  // Debug area first, then RAM with its alias, then tohost on the data port
  function automatic region_e decode(addr_t addr, logic dbg, logic data_port);
    region_e region;
    logic    in_window;
    in_window = (addr[31:14] == RAM_BASE[31:14]) || (addr[31:14] == ALIAS_TAG);
    region = REGION_NONE;
    if (dbg && (addr >= DEBUG_START) && (addr <= DEBUG_END))
      region = REGION_DEBUG;
    else if (in_window && ({18'd0, addr[13:0]} < RAM_BYTES))
      region = REGION_RAM;
    else if (data_port && (addr == TOHOST_ADDR))
      region = REGION_TOHOST;
    return region;
  endfunction

  assign imem_region = decode(i_imem_req.addr, i_debug_mode, 1'b0);
  assign dmem_region = decode(i_dmem_req.addr, i_debug_mode, 1'b1);

  // ====================
  // Request steering
  // ====================
  // Both windows share the low 14 bits as RAM offset
  assign o_ram_imem_idx   = i_imem_req.addr[13:2];
  assign o_ram_dmem_idx   = i_dmem_req.addr[13:2];
  assign o_ram_wdata      = i_dmem_req.wdata;
  assign o_ram_imem_rd    = i_imem_req.rready && (imem_region == REGION_RAM);
  assign o_ram_dmem_rd    = i_dmem_req.rready && (dmem_region == REGION_RAM);
  assign o_ram_dmem_wr    = i_dmem_req.wvalid && (dmem_region == REGION_RAM);

  assign o_dbg_imem_req   = i_imem_req.rready && (imem_region == REGION_DEBUG);
  assign o_dbg_imem_addr  = i_imem_req.addr[12:0];
  assign o_dbg_dmem_req   = (i_dmem_req.wvalid || i_dmem_req.rready) &&
                            (dmem_region == REGION_DEBUG);
  assign o_dbg_dmem_write = i_dmem_req.wvalid;
  assign o_dbg_dmem_addr  = i_dmem_req.addr[12:0];
  assign o_dbg_wdata      = i_dmem_req.wdata;

  // ====================
  // Responses
  // ====================
  always_comb
  begin
    o_imem_rsp = '0;
    case (imem_region)
      REGION_RAM:
      begin
        o_imem_rsp.rvalid = i_ram_imem_valid;
        o_imem_rsp.rdata  = i_ram_imem_rdata;
      end
      REGION_DEBUG:
      begin
        o_imem_rsp.rvalid = i_dbg_imem_done;
        o_imem_rsp.rdata  = i_dbg_rdata;
      end
      // Unmapped fetch reads zero at once
      default: o_imem_rsp.rvalid = i_imem_req.rready;
    endcase
  end

  always_comb
  begin
    o_dmem_rsp = '0;
    case (dmem_region)
      REGION_RAM:
      begin
        // RAM write never waits since writes win the grant
        o_dmem_rsp.wready = i_dmem_req.wvalid;
        o_dmem_rsp.rvalid = i_ram_dmem_valid;
        o_dmem_rsp.rdata  = i_ram_dmem_rdata;
      end
      REGION_DEBUG:
      begin
        o_dmem_rsp.wready = i_dbg_dmem_done && i_dmem_req.wvalid;
        o_dmem_rsp.rvalid = i_dbg_dmem_done && i_dmem_req.rready;
        o_dmem_rsp.rdata  = i_dbg_rdata;
      end
      // tohost and unmapped answer in the same cycle and read zero
      default:
      begin
        o_dmem_rsp.wready = i_dmem_req.wvalid;
        o_dmem_rsp.rvalid = i_dmem_req.rready;
      end
    endcase
  end

  // tohost register for test status
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_tohost <= '0;
    else if (i_dmem_req.wvalid && (dmem_region == REGION_TOHOST))
      o_tohost <= i_dmem_req.wdata;
  end

  // Core data port is either a load or a store in any cycle
  a_dmem_one_dir: assert property (@(posedge clk) disable iff (!reset_n)
    !(i_dmem_req.wvalid && i_dmem_req.rready));

  // Core holds a pending read until rvalid so the decode sees a stable address
  a_imem_hold: assert property (@(posedge clk) disable iff (!reset_n)
    i_imem_req.rready && !o_imem_rsp.rvalid |=>
      i_imem_req.rready && $stable(i_imem_req.addr));

  a_dmem_hold: assert property (@(posedge clk) disable iff (!reset_n)
    i_dmem_req.rready && !o_dmem_rsp.rvalid |=>
      i_dmem_req.rready && $stable(i_dmem_req.addr));

endmodule

// ==== verilog/mem_map_pkg.sv ====
// Address map, width types and port structs of the memory subsystem
// Imported by every RTL module of the subsystem and by the testbench
package mem_map_pkg;

  // ====================
  // Width types
  // ====================
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [11:0] word_idx_t;
  typedef logic [12:0] apb_addr_t;

  // Target of one core access
  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_DEBUG,
    REGION_TOHOST,
    REGION_NONE
  } region_e;

  // ====================
  // Address map
  // ====================
  localparam addr_t       RAM_BASE    = 32'h0001_0000;
  localparam int          RAM_WORDS   = 4096;
  // Debug module area, only decoded in debug mode
  localparam addr_t       DEBUG_START = 32'h0000_0200;
  localparam addr_t       DEBUG_END   = 32'h0000_0FFF;
  // Top field of the 0xFFFFC000 alias of the RAM
  localparam logic [17:0] ALIAS_TAG   = 18'h3FFFF;

  // ====================
  // Port structs
  // ====================
  typedef struct packed {
    logic  rready;
    addr_t addr;
  } imem_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } imem_rsp_t;

  typedef struct packed {
    logic  wvalid;
    logic  rready;
    addr_t addr;
    data_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic  wready;
    logic  rvalid;
    data_t rdata;
  } dmem_rsp_t;

  // APB master side towards the debug module
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    data_t     pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    logic  pslverr;
    data_t prdata;
  } apb_rsp_t;

endpackage
